//--- src/carry_pkg.sv
// Shared widths, byte constants and enums for the carry-resolution stage
// Only bit 8 of a word is treated as the carry; bits 15:9 are ignored
package carry_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int byte_w = 8;
    localparam int word_w = 16;
    localparam int run_w  = 8;

    // Input beat to output record, in cycles
    localparam int pipe_lat = 3;

    typedef logic [byte_w-1:0] byte_t;
    typedef logic [word_w-1:0] word_t;
    typedef logic [run_w-1:0]  run_t;

    // Number of tail bytes in a record, 0 to 2
    typedef logic [1:0] tail_t;

    // A byte of this value can be absorbed into a run
    localparam byte_t byte_ff = {byte_w{1'b1}};

    // ------------------------------
    // Enums
    // ------------------------------

    // Number of words carried by one input beat
    typedef enum logic [1:0] {
        op_idle = 2'd0,
        op_one  = 2'd1,
        op_two  = 2'd2
    } op_e;

    // Pending words are 0xFF with no carry and may extend a run
    typedef enum logic [1:0] {
        cls_absent    = 2'd0,
        cls_pending   = 2'd1,
        cls_resolving = 2'd2
    } word_class_e;

endpackage

//--- src/carry_decode.sv
// Input register stage; accepts a beat every cycle with no back-pressure
// Op codes outside the enum are treated as idle
module carry_decode (
    input  logic                   clk,
    input  logic                   rst_n,
    input  carry_pkg::op_e         in_op,
    input  logic                   in_first,
    input  logic                   in_final,
    input  carry_pkg::word_t       in_word_a,
    input  carry_pkg::word_t       in_word_b,
    output logic                   dec_valid,
    output logic                   dec_first,
    output logic                   dec_final,
    output carry_pkg::word_t       dec_word_a,
    output carry_pkg::word_t       dec_word_b,
    output carry_pkg::word_class_e dec_class_a,
    output carry_pkg::word_class_e dec_class_b
);
    import carry_pkg::*;

    logic        present_a;
    logic        present_b;
    logic        beat_valid;
    word_class_e class_a;
    word_class_e class_b;

    // A word stays pending only if it can still be swallowed by a later carry
    function automatic word_class_e classify(input logic present, input word_t word);
        word_class_e cls;
        if (!present) begin
            cls = cls_absent;
        end else if ((word[byte_w-1:0] == byte_ff) && !word[byte_w]) begin
            cls = cls_pending;
        end else begin
            cls = cls_resolving;
        end
        return cls;
    endfunction

    always_comb begin
        case (in_op)
            op_one: begin
                present_a = 1'b1;
                present_b = 1'b0;
            end
            op_two: begin
                present_a = 1'b1;
                present_b = 1'b1;
            end
            default: begin
                present_a = 1'b0;
                present_b = 1'b0;
            end
        endcase
    end

    assign class_a    = classify(present_a, in_word_a);
    assign class_b    = classify(present_b, in_word_b);
    assign beat_valid = present_a || in_first || in_final;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid   <= 1'b0;
            dec_first   <= 1'b0;
            dec_final   <= 1'b0;
            dec_class_a <= cls_absent;
            dec_class_b <= cls_absent;
        end else begin
            dec_valid   <= beat_valid;
            dec_first   <= in_first;
            dec_final   <= in_final;
            dec_class_a <= class_a;
            dec_class_b <= class_b;
        end
    end

    always_ff @(posedge clk) begin
        dec_word_a <= in_word_a;
        dec_word_b <= in_word_b;
    end

endmodule

//--- src/carry_execute.sv
// Holds the last non-0xFF byte and the 0xFF run behind it across beats
// Runs longer than 255 bytes and carries past the first byte of a block are not handled
module carry_execute (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   dec_valid,
    input  logic                   dec_first,
    input  logic                   dec_final,
    input  carry_pkg::word_t       dec_word_a,
    input  carry_pkg::word_t       dec_word_b,
    input  carry_pkg::word_class_e dec_class_a,
    input  carry_pkg::word_class_e dec_class_b,
    output logic                   exe_valid,
    output logic                   exe_last,
    output logic                   exe_head_valid,
    output carry_pkg::byte_t       exe_head,
    output carry_pkg::run_t        exe_run_len,
    output carry_pkg::byte_t       exe_run_byte,
    output carry_pkg::tail_t       exe_tail_count,
    output carry_pkg::byte_t       exe_tail_a,
    output carry_pkg::byte_t       exe_tail_b
);
    import carry_pkg::*;

    // ------------------------------
    // Held state
    // ------------------------------
    byte_t       held;
    logic        held_valid;
    run_t        run_cnt;

    // Beat seen as two lanes, lane 0 is word a
    word_class_e lane_cls   [2];
    byte_t       lane_low   [2];
    logic        lane_carry [2];

    // Next state and the record under construction
    byte_t       held_nx;
    logic        held_valid_nx;
    run_t        run_nx;
    logic        resolved;
    logic        head_valid_nx;
    byte_t       head_nx;
    run_t        run_len_nx;
    byte_t       run_byte_nx;
    tail_t       tail_count_nx;
    byte_t       tail_nx [2];

    assign lane_cls[0]   = dec_class_a;
    assign lane_cls[1]   = dec_class_b;
    assign lane_low[0]   = dec_word_a[byte_w-1:0];
    assign lane_low[1]   = dec_word_b[byte_w-1:0];
    assign lane_carry[0] = dec_word_a[byte_w];
    assign lane_carry[1] = dec_word_b[byte_w];

    // ------------------------------
    // Resolution of one beat
    // ------------------------------
    always_comb begin
        // A block start throws away whatever was still held
        held_valid_nx = held_valid && !dec_first;
        held_nx       = held;
        run_nx        = dec_first ? '0 : run_cnt;
        resolved      = 1'b0;
        head_valid_nx = 1'b0;
        head_nx       = '0;
        run_len_nx    = '0;
        run_byte_nx   = '0;
        tail_count_nx = '0;
        tail_nx[0]    = '0;
        tail_nx[1]    = '0;

        for (int i = 0; i < 2; i++) begin
            if (lane_cls[i] == cls_pending) begin
                if (held_valid_nx) begin
                    run_nx = run_nx + run_t'(1);
                end else begin
                    held_valid_nx = 1'b1;
                    held_nx       = lane_low[i];
                end
            end else if (lane_cls[i] == cls_resolving) begin
                if (held_valid_nx && resolved) begin
                    // Word b settles word a, which was held with an empty run
                    tail_nx[tail_count_nx[0]] = held_nx + byte_t'(lane_carry[i]);
                    tail_count_nx             = tail_count_nx + tail_t'(1);
                end else if (held_valid_nx) begin
                    head_valid_nx = 1'b1;
                    head_nx       = held_nx + byte_t'(lane_carry[i]);
                    run_len_nx    = run_nx;
                    run_byte_nx   = lane_carry[i] ? '0 : byte_ff;
                end
                held_valid_nx = 1'b1;
                held_nx       = lane_low[i];
                run_nx        = '0;
                resolved      = 1'b1;
            end
        end

        // Flush on final; the bytes pass with no carry
        if (dec_final && held_valid_nx) begin
            if (resolved) begin
                // Held byte came in this beat, so at most one 0xFF follows it
                tail_nx[tail_count_nx[0]] = held_nx;
                tail_count_nx             = tail_count_nx + tail_t'(1);
                if (run_nx != '0) begin
                    tail_nx[tail_count_nx[0]] = byte_ff;
                    tail_count_nx             = tail_count_nx + tail_t'(1);
                end
            end else begin
                head_valid_nx = 1'b1;
                head_nx       = held_nx;
                run_len_nx    = run_nx;
                run_byte_nx   = byte_ff;
            end
        end

        if (dec_final) begin
            held_valid_nx = 1'b0;
            run_nx        = '0;
        end
    end

    // ------------------------------
    // Registers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held_valid     <= 1'b0;
            run_cnt        <= '0;
            exe_valid      <= 1'b0;
            exe_last       <= 1'b0;
            exe_head_valid <= 1'b0;
            exe_run_len    <= '0;
            exe_tail_count <= '0;
        end else begin
            held_valid     <= held_valid_nx;
            run_cnt        <= run_nx;
            exe_valid      <= dec_valid;
            exe_last       <= dec_valid && dec_final;
            exe_head_valid <= head_valid_nx;
            exe_run_len    <= run_len_nx;
            exe_tail_count <= tail_count_nx;
        end
    end

    always_ff @(posedge clk) begin
        held         <= held_nx;
        exe_head     <= head_nx;
        exe_run_byte <= run_byte_nx;
        exe_tail_a   <= tail_nx[0];
        exe_tail_b   <= tail_nx[1];
    end

endmodule

//--- src/carry_result.sv
// Output register stage; byte fields of lanes that are not valid read as zero
// A record is emitted for any byte or for the last beat of a block
module carry_result (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             exe_valid,
    input  logic             exe_last,
    input  logic             exe_head_valid,
    input  carry_pkg::byte_t exe_head,
    input  carry_pkg::run_t  exe_run_len,
    input  carry_pkg::byte_t exe_run_byte,
    input  carry_pkg::tail_t exe_tail_count,
    input  carry_pkg::byte_t exe_tail_a,
    input  carry_pkg::byte_t exe_tail_b,
    output logic             out_valid,
    output logic             out_last,
    output logic             out_head_valid,
    output carry_pkg::byte_t out_head,
    output carry_pkg::run_t  out_run_len,
    output carry_pkg::byte_t out_run_byte,
    output carry_pkg::tail_t out_tail_count,
    output carry_pkg::byte_t out_tail_a,
    output carry_pkg::byte_t out_tail_b
);
    import carry_pkg::*;

    logic  head_on;
    logic  run_on;
    logic  last_on;
    tail_t tail_cnt;
    run_t  run_len;
    byte_t head_m;
    byte_t run_byte_m;
    byte_t tail_a_m;
    byte_t tail_b_m;

    // Lane enables, all qualified by the record valid
    assign head_on  = exe_valid && exe_head_valid;
    assign run_on   = exe_valid && (exe_run_len != '0);
    assign last_on  = exe_valid && exe_last;
    assign tail_cnt = exe_valid ? exe_tail_count : '0;
    assign run_len  = run_on ? exe_run_len : '0;

    assign head_m     = head_on ? exe_head : '0;
    assign run_byte_m = run_on ? exe_run_byte : '0;
    assign tail_a_m   = (tail_cnt != '0) ? exe_tail_a : '0;
    assign tail_b_m   = (tail_cnt == tail_t'(2)) ? exe_tail_b : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid      <= 1'b0;
            out_last       <= 1'b0;
            out_head_valid <= 1'b0;
            out_run_len    <= '0;
            out_tail_count <= '0;
        end else begin
            out_valid      <= head_on || run_on || (tail_cnt != '0) || last_on;
            out_last       <= last_on;
            out_head_valid <= head_on;
            out_run_len    <= run_len;
            out_tail_count <= tail_cnt;
        end
    end

    always_ff @(posedge clk) begin
        out_head     <= head_m;
        out_run_byte <= run_byte_m;
        out_tail_a   <= tail_a_m;
        out_tail_b   <= tail_b_m;
    end

endmodule

//--- src/carry_resolver_top.sv
// Carry-resolution stage, three register stages from input beat to output record
// Always ready; the source must respect the run length and carry limits of the package
module carry_resolver_top (
    input  logic             clk,
    input  logic             rst_n,
    input  carry_pkg::op_e   in_op,
    input  logic             in_first,
    input  logic             in_final,
    input  carry_pkg::word_t in_word_a,
    input  carry_pkg::word_t in_word_b,
    output logic             out_valid,
    output logic             out_last,
    output logic             out_head_valid,
    output carry_pkg::byte_t out_head,
    output carry_pkg::run_t  out_run_len,
    output carry_pkg::byte_t out_run_byte,
    output carry_pkg::tail_t out_tail_count,
    output carry_pkg::byte_t out_tail_a,
    output carry_pkg::byte_t out_tail_b
);
    import carry_pkg::*;

    // Decode to execute
    logic        dec_valid;
    logic        dec_first;
    logic        dec_final;
    word_t       dec_word_a;
    word_t       dec_word_b;
    word_class_e dec_class_a;
    word_class_e dec_class_b;

    // Execute to result
    logic        exe_valid;
    logic        exe_last;
    logic        exe_head_valid;
    byte_t       exe_head;
    run_t        exe_run_len;
    byte_t       exe_run_byte;
    tail_t       exe_tail_count;
    byte_t       exe_tail_a;
    byte_t       exe_tail_b;

    carry_decode decode0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_op       (in_op),
        .in_first    (in_first),
        .in_final    (in_final),
        .in_word_a   (in_word_a),
        .in_word_b   (in_word_b),
        .dec_valid   (dec_valid),
        .dec_first   (dec_first),
        .dec_final   (dec_final),
        .dec_word_a  (dec_word_a),
        .dec_word_b  (dec_word_b),
        .dec_class_a (dec_class_a),
        .dec_class_b (dec_class_b)
    );

    carry_execute execute0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .dec_valid      (dec_valid),
        .dec_first      (dec_first),
        .dec_final      (dec_final),
        .dec_word_a     (dec_word_a),
        .dec_word_b     (dec_word_b),
        .dec_class_a    (dec_class_a),
        .dec_class_b    (dec_class_b),
        .exe_valid      (exe_valid),
        .exe_last       (exe_last),
        .exe_head_valid (exe_head_valid),
        .exe_head       (exe_head),
        .exe_run_len    (exe_run_len),
        .exe_run_byte   (exe_run_byte),
        .exe_tail_count (exe_tail_count),
        .exe_tail_a     (exe_tail_a),
        .exe_tail_b     (exe_tail_b)
    );

    carry_result result0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .exe_valid      (exe_valid),
        .exe_last       (exe_last),
        .exe_head_valid (exe_head_valid),
        .exe_head       (exe_head),
        .exe_run_len    (exe_run_len),
        .exe_run_byte   (exe_run_byte),
        .exe_tail_count (exe_tail_count),
        .exe_tail_a     (exe_tail_a),
        .exe_tail_b     (exe_tail_b),
        .out_valid      (out_valid),
        .out_last       (out_last),
        .out_head_valid (out_head_valid),
        .out_head       (out_head),
        .out_run_len    (out_run_len),
        .out_run_byte   (out_run_byte),
        .out_tail_count (out_tail_count),
        .out_tail_a     (out_tail_a),
        .out_tail_b     (out_tail_b)
    );

endmodule

//--- tb/carry_resolver_sva.sv
// Timing and output-encoding checks, bound to the carry resolver top level
// Failures surface only as assertion errors
module carry_resolver_sva (
    input logic             clk,
    input logic             rst_n,
    input logic             in_final,
    input logic             out_valid,
    input logic             out_last,
    input carry_pkg::run_t  out_run_len,
    input carry_pkg::byte_t out_run_byte,
    input carry_pkg::tail_t out_tail_count
);
    import carry_pkg::*;

    // Output registers are cleared by reset and stay clear one more cycle
    assert property (@(posedge clk)
        !rst_n |=> (!out_valid && !out_last) ##1 (!out_valid && !out_last))
        else $error("Output record active during or right after reset");

    assert property (@(posedge clk) disable iff (!rst_n)
        in_final |-> ##(pipe_lat) out_last)
        else $error("out_last missing pipe_lat cycles after in_final");

    assert property (@(posedge clk) disable iff (!rst_n)
        out_last |-> $past(in_final, pipe_lat))
        else $error("out_last without a final beat pipe_lat cycles earlier");

    // A run is made of 0xFF bytes that either passed or wrapped to zero
    assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && (out_run_len != '0)) |-> (out_run_byte == byte_ff || out_run_byte == '0))
        else $error("Run byte is neither 0xFF nor 0x00");

    assert property (@(posedge clk) disable iff (!rst_n)
        out_tail_count <= tail_t'(2))
        else $error("Tail count above two");

endmodule

bind carry_resolver_top carry_resolver_sva sva0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_final       (in_final),
    .out_valid      (out_valid),
    .out_last       (out_last),
    .out_run_len    (out_run_len),
    .out_run_byte   (out_run_byte),
    .out_tail_count (out_tail_count)
);

//--- tb/tb_carry_resolver.sv
// Testbench for the carry resolver; expected streams are a big-number sum per block
// Stimulus keeps the first word of a block below 0xFF with no carry, and runs short
module tb_carry_resolver;
    import carry_pkg::*;

    localparam int          wait_limit = 40;
    localparam logic [31:0] lfsr_poly  = 32'h8020_0003;

    logic                clk = 1'b0;
    logic                rst_n;
    op_e                 in_op;
    logic                in_first;
    logic                in_final;
    word_t               in_word_a;
    word_t               in_word_b;
    logic                out_valid;
    logic                out_last;
    logic                out_head_valid;
    byte_t               out_head;
    run_t                out_run_len;
    byte_t               out_run_byte;
    tail_t               out_tail_count;
    byte_t               out_tail_a;
    byte_t               out_tail_b;

    logic [31:0]         lfsr;
    logic [pipe_lat-1:0] first_pipe;
    word_t               words_q [$];
    word_t               dir_q [$];
    byte_t               exp_q [$];
    byte_t               got_q [$];
    logic                block_done;
    run_t                run_len_seen;
    byte_t               run_byte_seen;
    string               test_name;

    carry_resolver_top dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_op          (in_op),
        .in_first       (in_first),
        .in_final       (in_final),
        .in_word_a      (in_word_a),
        .in_word_b      (in_word_b),
        .out_valid      (out_valid),
        .out_last       (out_last),
        .out_head_valid (out_head_valid),
        .out_head       (out_head),
        .out_run_len    (out_run_len),
        .out_run_byte   (out_run_byte),
        .out_tail_count (out_tail_count),
        .out_tail_a     (out_tail_a),
        .out_tail_b     (out_tail_b)
    );

    always #5 clk = ~clk;

    // ------------------------------
    // Output collector
    // ------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            first_pipe <= '0;
        end else begin
            // The record of a block-start beat holds only bytes of the new block
            if (first_pipe[pipe_lat-1]) begin
                got_q.delete();
                run_len_seen  = '0;
                run_byte_seen = '0;
            end
            if (out_valid) begin
                if (out_head_valid) begin
                    got_q.push_back(out_head);
                end
                for (int k = 0; k < int'(out_run_len); k++) begin
                    got_q.push_back(out_run_byte);
                end
                if (out_run_len != '0) begin
                    run_len_seen  = out_run_len;
                    run_byte_seen = out_run_byte;
                end
                if (out_tail_count != '0) begin
                    got_q.push_back(out_tail_a);
                end
                if (out_tail_count == tail_t'(2)) begin
                    got_q.push_back(out_tail_b);
                end
                if (out_last) begin
                    block_done = 1'b1;
                end
            end
            first_pipe <= {first_pipe[pipe_lat-2:0], in_first};
        end
    end

    // ------------------------------
    // Random source and stimulus
    // ------------------------------
    function automatic logic lfsr_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ lfsr_poly;
        end
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // The lead word of a block never carries and is never 0xFF
    function automatic word_t make_word(input logic lead);
        logic [31:0] r;
        byte_t       low;
        logic        c;
        c = 1'b0;
        r = rand_bits(2);
        if (!lead && r == 32'd0) begin
            low = byte_ff;
        end else begin
            low = byte_t'(rand_bits(8));
            if (!lead) begin
                r = rand_bits(1);
                c = r[0];
            end
        end
        if (lead && low == byte_ff) begin
            low = 8'h7f;
        end
        if (low == byte_ff) begin
            c = 1'b0;
        end
        return {7'd0, c, low};
    endfunction

    task automatic send_beat(input op_e op, input logic first, input logic fin,
                             input word_t wa, input word_t wb);
        @(posedge clk);
        in_op     <= op;
        in_first  <= first;
        in_final  <= fin;
        in_word_a <= wa;
        in_word_b <= wb;
        if (first) begin
            words_q.delete();
        end
        if (op == op_one || op == op_two) begin
            words_q.push_back(wa);
        end
        if (op == op_two) begin
            words_q.push_back(wb);
        end
    endtask

    task automatic send_idle();
        send_beat(op_idle, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic random_block(input int n_words, input logic close);
        int          remaining;
        int          cnt;
        logic        lead;
        logic [31:0] r;
        op_e         op;
        word_t       wa;
        word_t       wb;
        remaining = n_words;
        lead      = 1'b1;
        while (remaining > 0) begin
            if (!lead) begin
                r = rand_bits(2);
                if (r == 32'd0) begin
                    send_idle();
                end
            end
            r   = rand_bits(1);
            cnt = (remaining >= 2 && r[0]) ? 2 : 1;
            wa  = make_word(lead);
            wb  = '0;
            op  = op_one;
            if (cnt == 2) begin
                wb = make_word(1'b0);
                op = op_two;
            end
            remaining = remaining - cnt;
            send_beat(op, lead, close && remaining == 0, wa, wb);
            lead = 1'b0;
        end
    endtask

    task automatic send_directed();
        for (int i = 0; i < dir_q.size(); i++) begin
            send_beat(op_one, i == 0, i == dir_q.size() - 1, dir_q[i], '0);
        end
        dir_q.delete();
    endtask

    // ------------------------------
    // Golden model and checks
    // ------------------------------

    // Word i adds its low byte at position i and its carry at position i-1
    task automatic build_expected();
        int         n;
        logic [8:0] acc;
        logic       c;
        n = words_q.size();
        exp_q.delete();
        for (int i = 0; i < n; i++) begin
            exp_q.push_back('0);
        end
        c = 1'b0;
        for (int i = n - 1; i >= 0; i--) begin
            acc = {1'b0, words_q[i][7:0]} + {8'd0, c};
            if (i + 1 < n) begin
                acc = acc + {8'd0, words_q[i+1][8]};
            end
            exp_q[i] = acc[7:0];
            c        = acc[8];
        end
    endtask

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopping at the first failure");
    endtask

    task automatic wait_block_done();
        int cycles;
        cycles = 0;
        while (!block_done && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!block_done) begin
            $display("Timed out waiting for out_last in test %s", test_name);
            abort_run();
        end
    endtask

    task automatic finish_block();
        send_idle();
        build_expected();
        wait_block_done();
        assert (got_q.size() == exp_q.size()) else begin
            $display("[ERROR] %s length: expected %0d, actual %0d",
                     test_name, exp_q.size(), got_q.size());
            abort_run();
        end
        for (int i = 0; i < exp_q.size(); i++) begin
            assert (got_q[i] == exp_q[i]) else begin
                $display("[ERROR] %s byte %0d: expected %02h, actual %02h",
                         test_name, i, exp_q[i], got_q[i]);
                abort_run();
            end
        end
        got_q.delete();
        block_done = 1'b0;
    endtask

    task automatic check_run(input run_t exp_len, input byte_t exp_byte);
        assert (run_len_seen == exp_len) else begin
            $display("[ERROR] %s run length: expected %0d, actual %0d",
                     test_name, exp_len, run_len_seen);
            abort_run();
        end
        assert (run_byte_seen == exp_byte) else begin
            $display("[ERROR] %s run byte: expected %02h, actual %02h",
                     test_name, exp_byte, run_byte_seen);
            abort_run();
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        lfsr       = 32'h8abb_57b0;
        rst_n      = 1'b0;
        in_op      = op_idle;
        in_first   = 1'b0;
        in_final   = 1'b0;
        in_word_a  = '0;
        in_word_b  = '0;
        block_done = 1'b0;
        test_name  = "reset";
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            assert (!out_valid && !out_last) else begin
                $display("Output record appeared after reset with no beat in test %s",
                         test_name);
                abort_run();
            end
        end

        test_name = "no_carry";
        for (int i = 0; i < 8; i++) begin
            dir_q.push_back(word_t'(16 + 17 * i));
        end
        send_directed();
        finish_block();

        test_name = "carry_held";
        dir_q.push_back(16'h0041);
        dir_q.push_back(16'h0152);
        dir_q.push_back(16'h0163);
        dir_q.push_back(16'h0007);
        send_directed();
        finish_block();

        test_name = "run_carry";
        dir_q.push_back(16'h0012);
        for (int i = 0; i < 3; i++) begin
            dir_q.push_back(16'h00ff);
        end
        dir_q.push_back(16'h0134);
        send_directed();
        finish_block();
        check_run(run_t'(3), 8'h00);

        test_name = "run_no_carry";
        dir_q.push_back(16'h0012);
        for (int i = 0; i < 3; i++) begin
            dir_q.push_back(16'h00ff);
        end
        dir_q.push_back(16'h0034);
        send_directed();
        finish_block();
        check_run(run_t'(3), byte_ff);

        test_name = "random_blocks";
        for (int b = 0; b < 20; b++) begin
            random_block(4 + int'(rand_bits(5)), 1'b1);
            finish_block();
        end

        // Second block starts while the first still holds bytes
        test_name = "restart";
        random_block(6, 1'b0);
        random_block(10, 1'b1);
        finish_block();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- build.f
src/carry_pkg.sv
src/carry_decode.sv
src/carry_execute.sv
src/carry_result.sv
src/carry_resolver_top.sv
tb/carry_resolver_sva.sv
tb/tb_carry_resolver.sv

//--- run.sh
#!/bin/sh
# Builds the carry-resolution testbench with Verilator and runs it.
# The run passes only when the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert \
    --top-module tb_carry_resolver \
    -f build.f \
    --Mdir obj_dir \
    -o sim_carry_resolver
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_carry_resolver > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\*\* TEST PASSED \*\*\*$' "$log_file"; then
    echo "Simulation result: pass"
    exit 0
else
    echo "Simulation result: fail, see $log_file"
    exit 1
fi
